//--- ttc_trace.txt
# op data idle l1a_count, all hex. op 0 nop, 1 bx0, 2 resync, 3 l1a, 4 set-offset
# bx0 data 1 waits to land on the offset, op 5 waits for cmd_ready low, op 6 holds header_ready
0 000 3 0
1 001 5 0
3 000 14 1
1 001 2 0
3 000 28 2
1 000 7 0
3 000 3 3
4 00a 2 0
2 000 4 0
1 001 3 0
3 000 5 1
1 001 3 0
4 064 2 0
2 000 6 0
3 000 2 1
1 001 1e 0
6 001 0 0
3 000 0 2
3 000 0 3
3 000 0 4
3 000 0 5
5 000 8 0
6 000 0 0
3 000 6 6
1 001 20 0
0 000 40 0

//--- project.f
ttc_pkg.sv
ttc_cmd_decode.sv
ttc_bx_counter.sv
ttc_l1a_header.sv
ttc_subsystem.sv
ttc_subsystem_checker.sv
tb_ttc_subsystem.sv

//--- Bender.yml
package:
  name: ttc_subsystem

sources:
  - ttc_pkg.sv
  - ttc_cmd_decode.sv
  - ttc_bx_counter.sv
  - ttc_l1a_header.sv
  - ttc_subsystem.sv
  - target: simulation
    files:
      - ttc_subsystem_checker.sv
      - tb_ttc_subsystem.sv

//--- tb_ttc_subsystem.sv
// Trace-driven testbench for ttc_subsystem with 64 bunches per orbit.
// Reads ttc_trace.txt from the working directory, run from the project root.
// A cycle model predicts status every cycle and every event header.
// Inputs change on the falling edge, outputs are sampled around the rising edge.
`timescale 1ns/1ps

module tb_ttc_subsystem;
  import ttc_pkg::*;

  localparam int unsigned lhc = 64;
  localparam int tmo = 400;  // Cycles allowed for any wait

  logic        clock = 1'b0;
  logic        bxn_preset = 1'b1;
  ttc_cmd_t    cmd = '0;
  logic        cmd_valid = 1'b0;
  logic        cmd_ready;
  ttc_header_t header;
  logic        header_valid;
  logic        header_ready = 1'b0;
  ttc_status_t status;

  // Model state, all values after the last rising edge
  ttc_cmd_t         p1, p2;          // Commands accepted one and two edges ago
  logic             p1_v, p2_v;
  logic [bxn_w-1:0] m_off, m_lim, m_bxn;
  logic [cnt_w-1:0] m_orbit, m_lcl, m_rxd, m_l1a;
  logic             m_hold, m_err;
  ttc_header_t      exp_q[$];
  logic [cnt_w-1:0] cnt_q[$];        // l1a counts from the trace
  logic [31:0]      rnd = 32'h62f4;
  logic             hold_ready = 1'b0;

  ttc_subsystem #(.lhc_cycle(lhc)) i_dut (.*);

  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic fail_run(input string why);
    $display("error: %s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model and header monitor
  // ----------------------------------------------------------------------

  always @(posedge clock) begin
    logic        s_bx0, s_res, s_l1a, load;
    ttc_header_t h;
    if (header_valid && header_ready && !bxn_preset) begin
      if (exp_q.size() == 0) fail_run("header output without a pending l1a");
      h = exp_q.pop_front();
      check_value("header", header, h);
      check_value("header.l1a_count", header.l1a_count, cnt_q.pop_front());
    end
    if (bxn_preset) begin
      {p1_v, p2_v, m_err} = '0;
      {m_off, m_lim, m_bxn, m_orbit, m_lcl, m_rxd, m_l1a} = '0;
      m_hold = 1'b1;
    end else begin
      s_bx0 = p2_v && p2.opcode == ttc_bx0;  // Strobe sampled two edges after accept
      s_res = p2_v && p2.opcode == ttc_resync;
      s_l1a = p2_v && p2.opcode == ttc_l1a;
      load  = (m_hold || s_res) && !s_bx0;
      if (s_l1a) begin
        h.l1a_count = m_l1a + 1'b1;
        h.bxn       = m_bxn;
        h.orbit     = m_orbit;
        h.sync_err  = m_err;
        exp_q.push_back(h);
      end
      if (load) m_err = 1'b0;
      else if (s_bx0) m_err = m_err || (m_bxn != m_lim);
      else if (m_bxn == m_lim) m_err = 1'b1;  // Offset passed without bx0
      if (s_res) begin
        {m_orbit, m_lcl, m_rxd} = '0;
      end else begin
        if (m_bxn == lhc - 1 && m_orbit != '1) m_orbit++;
        if (m_bxn == 0) m_lcl++;
        if (s_bx0) m_rxd++;
      end
      if (s_res) m_l1a = '0;
      else if (s_l1a) m_l1a++;
      if (s_bx0) m_hold = 1'b0;
      m_bxn = load ? m_lim : (m_bxn == lhc - 1) ? '0 : m_bxn + 1'b1;
      m_lim = (m_off > lhc - 1) ? bxn_w'(lhc - 1) : m_off;  // Old offset
      if (p1_v && p1.opcode == ttc_set_offset) m_off = p1.data;
      p2 = p1;
      p2_v = p1_v;
      p1 = cmd;
      p1_v = cmd_valid && cmd_ready;
    end
  end

  // Status compare and header_ready gaps, on the falling edge
  always @(negedge clock) begin
    logic load_now;
    // Bound assertions count their failures
    if (i_dut.i_checker.fail_count != 0) fail_run("an assertion in the checker failed");
    if (!bxn_preset) begin
      load_now = (m_hold || (p2_v && p2.opcode == ttc_resync)) &&
                 !(p2_v && p2.opcode == ttc_bx0);
      check_value("status.bxn", status.bxn, m_bxn);
      check_value("status.orbit", status.orbit, m_orbit);
      check_value("status.bx0_lcl", status.bx0_lcl, m_lcl);
      check_value("status.bx0_rxd", status.bx0_rxd, m_rxd);
      check_value("status.bxn_sync_err", status.bxn_sync_err, m_err);
      check_value("status.bx0_sync_err", status.bx0_sync_err, m_err || load_now);
    end
    rnd = xorshift(rnd);
    header_ready = hold_ready ? 1'b0 : rnd[0];
  end

  // ----------------------------------------------------------------------
  // Command driver
  // ----------------------------------------------------------------------

  task automatic send_cmd(input logic [2:0] op, input logic [bxn_w-1:0] data);
    int n;
    cmd.opcode = ttc_opcode_e'(op);
    cmd.data   = data;
    cmd_valid  = 1'b1;
    n = 0;
    forever begin
      @(posedge clock);
      if (cmd_ready) break;  // Accepted at this edge
      n++;
      if (n > tmo) fail_run("command not accepted in time");
    end
    @(negedge clock);
    cmd_valid = 1'b0;
  endtask

  // Strobe compares bxn two edges after acceptance, so start two bunches early
  task automatic wait_bx0_slot();
    int n;
    n = 0;
    while (!(m_hold || m_bxn == (m_lim + lhc - 2) % lhc)) begin
      @(negedge clock);
      n++;
      if (n > tmo) fail_run("no slot for an aligned bx0");
    end
  endtask

  task automatic wait_ready_low();
    int n;
    n = 0;
    while (cmd_ready) begin
      @(negedge clock);
      n++;
      if (n > tmo) fail_run("cmd_ready did not fall with the FIFO full");
    end
  endtask

  initial begin
    int          fd, cyc;
    string       line;
    logic [31:0] op, data, idle, cnt;
    repeat (10) @(posedge clock);
    @(negedge clock);
    bxn_preset = 1'b0;
    fd = $fopen("ttc_trace.txt", "r");
    if (fd == 0) fail_run("cannot open ttc_trace.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if ($sscanf(line, "%h %h %h %h", op, data, idle, cnt) != 4) continue;
      case (op)
        5: wait_ready_low();
        6: hold_ready <= data[0];  // Takes effect at the next falling edge
        default: begin
          if (op == 1 && data[0]) wait_bx0_slot();
          if (op == 3) cnt_q.push_back(cnt[cnt_w-1:0]);
          send_cmd(op[2:0], data[bxn_w-1:0]);
        end
      endcase
      repeat (idle) @(negedge clock);
    end
    $fclose(fd);
    cyc = 0;
    while (exp_q.size() != 0) begin  // Drain all headers
      @(negedge clock);
      cyc++;
      if (cyc > tmo) fail_run("headers not drained");
    end
    if (i_dut.i_checker.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- ttc_subsystem_checker.sv
// Assertions bound into ttc_subsystem, inactive while bxn_preset is high.
// Strobe is an internal net of the top level. The FIFO fill level comes
// from the header stage.
`timescale 1ns/1ps

module ttc_subsystem_checker
  import ttc_pkg::*;
#(
  parameter int unsigned lhc_cycle = 3564
) (
  input logic        clock,
  input logic        bxn_preset,
  input logic        cmd_ready,
  input logic [2:0]  fifo_count,    // Entries held in the header FIFO
  input ttc_strobe_t strobe,
  input ttc_header_t header,
  input logic        header_valid,
  input logic        header_ready,
  input ttc_status_t status
);

  int unsigned fail_count = 0;  // Failed assertions so far

  // Bunch number stays inside the orbit
  bxn_in_orbit: assert property (@(posedge clock) disable iff (bxn_preset)
    status.bxn < lhc_cycle)
    else begin
      $error("bxn outside the orbit");
      fail_count++;
    end

  // Output word held while the sink stalls
  header_stable: assert property (@(posedge clock) disable iff (bxn_preset)
    header_valid && !header_ready |=> header_valid && $stable(header))
    else begin
      $error("header changed while header_ready was low");
      fail_count++;
    end

  // A full FIFO takes no command and no push
  full_blocks_cmd: assert property (@(posedge clock) disable iff (bxn_preset)
    fifo_count == 3'd4 |-> !cmd_ready && !strobe.l1a)
    else begin
      $error("command or l1a taken with header FIFO full");
      fail_count++;
    end

  strobe_onehot: assert property (@(posedge clock) disable iff (bxn_preset)
    $onehot0(strobe))  // At most one strobe per cycle
    else begin
      $error("more than one strobe high");
      fail_count++;
    end

endmodule

bind ttc_subsystem ttc_subsystem_checker #(
  .lhc_cycle (lhc_cycle)
) i_checker (
  .clock        (clock),
  .bxn_preset   (bxn_preset),
  .cmd_ready    (cmd_ready),
  .fifo_count   (i_header.count),
  .strobe       (strobe),
  .header       (header),
  .header_valid (header_valid),
  .header_ready (header_ready),
  .status       (status)
);

//--- ttc_subsystem.sv
// Top of the TTC timing block: decode, bunch counter and header FIFO.
// lhc_cycle and hold_until_bx0 pass down to the bunch counter unchanged.
// Commands and headers use valid/ready. Strobes between stages do not,
// since the counters never stall. Only command acceptance stops.
`timescale 1ns/1ps

module ttc_subsystem
  import ttc_pkg::*;
#(
  parameter int unsigned lhc_cycle      = 3564,  // Bunches per orbit
  parameter bit          hold_until_bx0 = 1'b1   // Hold bxn until first bx0
) (
  input  logic        clock,
  input  logic        bxn_preset,    // Synchronous reset, active high
  input  ttc_cmd_t    cmd,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  output ttc_header_t header,
  output logic        header_valid,
  input  logic        header_ready,
  output ttc_status_t status
);

  ttc_strobe_t      strobe;       // Decode to counter and header
  logic [bxn_w-1:0] bxn_offset;   // Offset register in decode
  logic             header_full;  // Header stage back to decode

  // ----------------------------------------------------------------------
  // Decode, execute, result
  // ----------------------------------------------------------------------

  ttc_cmd_decode i_decode (
    .clock       (clock),
    .bxn_preset  (bxn_preset),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .header_full (header_full),
    .strobe      (strobe),
    .bxn_offset  (bxn_offset)
  );

  ttc_bx_counter #(
    .lhc_cycle      (lhc_cycle),
    .hold_until_bx0 (hold_until_bx0)
  ) i_counter (
    .clock      (clock),
    .bxn_preset (bxn_preset),
    .strobe     (strobe),
    .bxn_offset (bxn_offset),
    .status     (status)
  );

  ttc_l1a_header i_header (
    .clock        (clock),
    .bxn_preset   (bxn_preset),
    .strobe       (strobe),
    .status       (status),  // Same status that goes to the top output
    .header       (header),
    .header_valid (header_valid),
    .header_ready (header_ready),
    .header_full  (header_full)
  );

endmodule

//--- ttc_l1a_header.sv
// Event header builder with a four-entry FIFO and a valid/ready output.
// An l1a strobe writes the status seen in the same cycle. The entry is
// visible after that edge, so the first transfer can come one edge later.
// header_full reserves room for l1as still inside decode. It may drop for
// single cycles near full, so senders must wait on cmd_ready.
// The l1a counter wraps at 2**cnt_w and clears on resync.
`timescale 1ns/1ps

module ttc_l1a_header
  import ttc_pkg::*;
(
  input  logic        clock,
  input  logic        bxn_preset,    // Synchronous reset
  input  ttc_strobe_t strobe,
  input  ttc_status_t status,
  output ttc_header_t header,
  output logic        header_valid,
  input  logic        header_ready,
  output logic        header_full    // Stops command acceptance in decode
);

  localparam int depth = 4;

  ttc_header_t      mem [depth];  // FIFO storage, no reset
  ttc_header_t      wr_entry;
  logic [1:0]       wr_ptr;
  logic [1:0]       rd_ptr;
  logic [2:0]       count;        // Entries held, 0..4
  logic [2:0]       reserved;     // Entries held plus l1as that may be in flight
  logic [cnt_w-1:0] l1a_cnt;
  logic             slot_open_q;  // Decode could accept at the last edge
  logic             push;
  logic             pop;

  // ----------------------------------------------------------------------
  // L1A counter and header build
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (bxn_preset || strobe.resync) begin
      l1a_cnt <= '0;
    end else if (strobe.l1a) begin
      l1a_cnt <= l1a_cnt + 1'b1;
    end
  end

  assign wr_entry.l1a_count = l1a_cnt + 1'b1;  // Count including this l1a
  assign wr_entry.bxn       = status.bxn;
  assign wr_entry.orbit     = status.orbit;
  assign wr_entry.sync_err  = status.bxn_sync_err;

  // ----------------------------------------------------------------------
  // FIFO
  // ----------------------------------------------------------------------

  assign push = strobe.l1a;  // Room is guaranteed by header_full
  assign pop  = header_valid && header_ready;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Four entries, pointer wraps
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign header       = mem[rd_ptr];
  assign header_valid = (count != '0);

  // ----------------------------------------------------------------------
  // Back-pressure
  // ----------------------------------------------------------------------

  // An l1a in decode's command register is not visible here. If ready was
  // high at the last edge, assume one was taken and keep a slot for it.
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      slot_open_q <= 1'b0;  // Decode takes nothing during reset
    end else begin
      slot_open_q <= ~header_full;
    end
  end

  assign reserved    = count + 3'(strobe.l1a) + 3'(slot_open_q);
  assign header_full = (reserved >= 3'(depth));

endmodule

//--- ttc_bx_counter.sv
// Bunch crossing counter, runs 0 to lhc_cycle-1 and wraps.
// Loads the limited offset on resync, and while held for the first bx0 when
// hold_until_bx0 is set. A bx0 in the same cycle overrides the load.
// Strobes are taken as single-cycle pulses with at most one high.
// The orbit counter saturates. The bx0 counters wrap at 2**cnt_w.
// bx0_sync_err is combinational from the load and the sticky error flag.
`timescale 1ns/1ps

module ttc_bx_counter
  import ttc_pkg::*;
#(
  parameter int unsigned lhc_cycle      = 3564,  // Bunches per orbit
  parameter bit          hold_until_bx0 = 1'b1   // Hold count until first bx0
) (
  input  logic             clock,
  input  logic             bxn_preset,  // Synchronous reset
  input  ttc_strobe_t      strobe,
  input  logic [bxn_w-1:0] bxn_offset,
  output ttc_status_t      status
);

  localparam logic [bxn_w-1:0] bxn_max = bxn_w'(lhc_cycle - 1);  // Last bunch

  logic [bxn_w-1:0] bxn_offset_lim;  // Offset clipped into the orbit
  logic [bxn_w-1:0] bxn_cnt;
  logic [cnt_w-1:0] orbit_cnt;
  logic [cnt_w-1:0] bx0_lcl_cnt;
  logic [cnt_w-1:0] bx0_rxd_cnt;
  logic             bxn_hold;        // Waiting for first bx0
  logic             bxn_sync_err;
  logic             bxn_load;        // Load limited offset this edge
  logic             bxn_ovf;         // Last bunch of the orbit
  logic             bxn_sync;        // Count sits at the offset
  logic             bx0_local;       // Count sits at zero
  logic             orbit_sat;

  // ----------------------------------------------------------------------
  // Offset limit and hold
  // ----------------------------------------------------------------------

  // Offsets past the orbit would give bunch numbers that never occur
  always_ff @(posedge clock) begin
    bxn_offset_lim <= (bxn_offset > bxn_max) ? bxn_max : bxn_offset;
  end

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      bxn_hold <= 1'b1;
    end else if (strobe.bx0) begin
      bxn_hold <= 1'b0;  // Released by the first bx0, set again only by reset
    end
  end

  // Resync followed by bx0 is the normal way to synchronize
  assign bxn_load = ((hold_until_bx0 && bxn_hold) || strobe.resync) && !strobe.bx0;

  // ----------------------------------------------------------------------
  // Bunch counter
  // ----------------------------------------------------------------------

  assign bxn_ovf   = (bxn_cnt == bxn_max);
  assign bxn_sync  = (bxn_cnt == bxn_offset_lim);  // Where the bx0 should land
  assign bx0_local = (bxn_cnt == '0);

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      bxn_cnt <= '0;
    end else if (bxn_load) begin
      bxn_cnt <= bxn_offset_lim;
    end else if (bxn_ovf) begin
      bxn_cnt <= '0;
    end else begin
      bxn_cnt <= bxn_cnt + 1'b1;
    end
  end

  // Error when a bx0 misses the offset, or the offset passes without a bx0
  always_ff @(posedge clock) begin
    if (bxn_preset || bxn_load) begin
      bxn_sync_err <= 1'b0;
    end else if (strobe.bx0) begin
      bxn_sync_err <= !bxn_sync || bxn_sync_err;
    end else if (bxn_sync) begin
      bxn_sync_err <= 1'b1;  // Offset reached, no bx0 with it
    end
  end

  // ----------------------------------------------------------------------
  // Orbit and bx0 counters
  // ----------------------------------------------------------------------

  assign orbit_sat = (orbit_cnt == '1);

  always_ff @(posedge clock) begin
    if (bxn_preset || strobe.resync) begin
      orbit_cnt   <= '0;
      bx0_lcl_cnt <= '0;
      bx0_rxd_cnt <= '0;
    end else begin
      if (bxn_ovf && !orbit_sat) orbit_cnt <= orbit_cnt + 1'b1;  // One per wrap
      if (bx0_local) bx0_lcl_cnt <= bx0_lcl_cnt + 1'b1;  // Also while held at zero
      if (strobe.bx0) bx0_rxd_cnt <= bx0_rxd_cnt + 1'b1;
    end
  end

  assign status.bxn          = bxn_cnt;
  assign status.orbit        = orbit_cnt;
  assign status.bx0_lcl      = bx0_lcl_cnt;
  assign status.bx0_rxd      = bx0_rxd_cnt;
  assign status.bxn_sync_err = bxn_sync_err;
  assign status.bx0_sync_err = bxn_sync_err || bxn_load;  // High during a load too

endmodule

//--- ttc_cmd_decode.sv
// Two register stages: the accepted command word, then the decoded strobes.
// A command accepted at edge k gives a strobe high for the cycle after edge
// k+1, and a set-offset writes bxn_offset at edge k+1.
// Commands are taken in order. Back-pressure from the header FIFO stalls
// every opcode, not only l1a.
// Opcodes outside ttc_opcode_e are accepted and dropped like a no-op.
`timescale 1ns/1ps

module ttc_cmd_decode
  import ttc_pkg::*;
(
  input  logic             clock,
  input  logic             bxn_preset,   // Synchronous reset
  input  ttc_cmd_t         cmd,
  input  logic             cmd_valid,
  output logic             cmd_ready,
  input  logic             header_full,  // No room for another l1a in flight
  output ttc_strobe_t      strobe,
  output logic [bxn_w-1:0] bxn_offset
);

  ttc_cmd_t cmd_q;        // Accepted command word
  logic     cmd_q_valid;  // cmd_q holds a command to decode
  logic     accept;

  assign cmd_ready = ~header_full;
  assign accept    = cmd_valid & cmd_ready;

  // ----------------------------------------------------------------------
  // Stage 1, command register
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      cmd_q_valid <= 1'b0;
    end else begin
      cmd_q_valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cmd_q <= cmd;  // Payload, no reset needed
    end
  end

  // ----------------------------------------------------------------------
  // Stage 2, strobes and offset register
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      strobe     <= '0;
      bxn_offset <= '0;
    end else begin
      strobe <= '0;  // Strobes last one cycle
      if (cmd_q_valid) begin
        case (cmd_q.opcode)
          ttc_bx0:        strobe.bx0    <= 1'b1;
          ttc_resync:     strobe.resync <= 1'b1;
          ttc_l1a:        strobe.l1a    <= 1'b1;
          ttc_set_offset: bxn_offset    <= cmd_q.data;  // Limited later in counter
          default: ;                                     // ttc_nop and unused codes
        endcase
      end
    end
  end

endmodule

//--- ttc_pkg.sv
// Widths, command opcodes and bus structs shared by the TTC timing block
// and its testbench.
// Bunch numbers are bxn_w bits wide, so lhc_cycle must stay at or below 4096.
// Counter widths are fixed here and are not module parameters.
// Opcode values 5 to 7 are not defined. Decode accepts them as no-ops.

package ttc_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  localparam int bxn_w = 12;  // Bunch number, LHC numbers bunches 0..3563
  localparam int cnt_w = 16;  // Orbit, bx0 and l1a counters

  // ----------------------------------------------------------------------
  // Command word
  // ----------------------------------------------------------------------

  typedef enum logic [2:0] {
    ttc_nop        = 3'd0,  // Accepted, no effect
    ttc_bx0        = 3'd1,  // Bunch crossing zero from the TTC
    ttc_resync     = 3'd2,  // Reload bunch counter, clear counters
    ttc_l1a        = 3'd3,  // Level-1 accept, builds an event header
    ttc_set_offset = 3'd4   // Load bunch counter offset from data
  } ttc_opcode_e;

  typedef struct packed {
    ttc_opcode_e      opcode;
    logic [bxn_w-1:0] data;    // Offset value, used by set-offset only
  } ttc_cmd_t;                 // 15 bits

  // Single-cycle strobes from decode, at most one high per cycle
  typedef struct packed {
    logic bx0;
    logic resync;
    logic l1a;
  } ttc_strobe_t;              // 3 bits

  // ----------------------------------------------------------------------
  // Status and event header
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [bxn_w-1:0] bxn;           // Bunch number
    logic [cnt_w-1:0] orbit;         // Orbits since resync, saturating
    logic [cnt_w-1:0] bx0_lcl;       // Local zeros of the bunch counter
    logic [cnt_w-1:0] bx0_rxd;       // Received bx0 commands
    logic             bxn_sync_err;  // Sticky until next load
    logic             bx0_sync_err;  // Sticky error, also high while loading
  } ttc_status_t;                    // 62 bits

  typedef struct packed {
    logic [cnt_w-1:0] l1a_count;  // Count of this l1a since resync, first is 1
    logic [bxn_w-1:0] bxn;
    logic [cnt_w-1:0] orbit;
    logic             sync_err;   // bxn_sync_err at the l1a
  } ttc_header_t;                 // 45 bits

endpackage
